// File: common/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Core sizes

`define MIPS_XLEN       32              // Data and address width.
`define MIPS_REG_COUNT  32              // Integer registers.

// ~~~~~~~~~~~~~~~~~~~~
// Fixed values

`define MIPS_RESET_PC   32'h0000_0000   // First fetch address.
`define MIPS_HALT_WORD  32'hffff_ffff   // Stops the core.

`endif

// File: common/mips_pkg.sv
`include "mips_settings.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_num_t;
    typedef logic [2:0]            alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // ~~~~~~~~~~~~~~~~~~~~
    // Opcodes and function codes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT
    } mem_state_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pipeline registers
    typedef struct packed {
        logic     valid;
        word_t    inst;
        word_t    pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    rs_data;
        word_t    rt_data;
        word_t    imm;
        word_t    pc_plus4;
        reg_num_t dest;
        alu_op_t  alu_op;
        logic     alu_src;      // Immediate as second operand.
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_result;
        word_t    store_data;
        reg_num_t dest;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     halt;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        reg_num_t dest;
        logic     reg_write;
        logic     halt;         // Sticky once a halt retires.
    } mem_wb_t;

endpackage

// File: logic/fetch_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             freeze,
    input  logic             branch_taken,
    input  mips_pkg::word_t  branch_target,
    input  logic             halt_seen,
    output mips_pkg::word_t  inst_addr,
    input  mips_pkg::word_t  inst,
    output mips_pkg::if_id_t if_id
);
    import mips_pkg::*;

    word_t pc;
    word_t pc_plus4;

    assign inst_addr = pc;
    assign pc_plus4  = pc + word_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `MIPS_RESET_PC;
            if_id.valid <= 1'b0;
        end else if (!freeze) begin
            if (branch_taken) begin
                pc <= branch_target;            // Redirect from execute.
            end else if (!halt_seen) begin
                pc <= pc_plus4;
            end
            if_id.inst     <= inst;
            if_id.pc_plus4 <= pc_plus4;
            if_id.valid    <= !branch_taken && !halt_seen;
        end
    end

endmodule

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               freeze,
    input  logic               branch_taken,
    input  mips_pkg::if_id_t   if_id,
    output mips_pkg::reg_num_t rs_num,
    output mips_pkg::reg_num_t rt_num,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output logic               halt_seen,
    output mips_pkg::id_ex_t   id_ex
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_num_t   rd_num;
    id_ex_t     id_ex_next;

    assign opcode = if_id.inst[31:26];
    assign funct  = if_id.inst[5:0];
    assign rs_num = if_id.inst[25:21];
    assign rt_num = if_id.inst[20:16];
    assign rd_num = if_id.inst[15:11];

    always_comb begin
        id_ex_next           = '0;
        id_ex_next.valid     = if_id.valid && !halt_seen && !branch_taken;
        id_ex_next.rs_data   = rs_data;
        id_ex_next.rt_data   = rt_data;
        id_ex_next.imm       = {{(`MIPS_XLEN-16){if_id.inst[15]}}, if_id.inst[15:0]};
        id_ex_next.pc_plus4  = if_id.pc_plus4;
        id_ex_next.dest      = rt_num;
        id_ex_next.alu_op    = ALU_ADD;
        if (if_id.inst == `MIPS_HALT_WORD) begin
            id_ex_next.halt = 1'b1;
        end else begin
            case (opcode)
                OP_RTYPE: begin
                    id_ex_next.dest      = rd_num;
                    id_ex_next.reg_write = 1'b1;
                    case (funct)
                        FN_ADD:  id_ex_next.alu_op = ALU_ADD;
                        FN_SUB:  id_ex_next.alu_op = ALU_SUB;
                        FN_AND:  id_ex_next.alu_op = ALU_AND;
                        FN_OR:   id_ex_next.alu_op = ALU_OR;
                        FN_SLT:  id_ex_next.alu_op = ALU_SLT;
                        default: id_ex_next.reg_write = 1'b0;   // Unknown function is a nop.
                    endcase
                end
                OP_ADDI: begin
                    id_ex_next.alu_src   = 1'b1;
                    id_ex_next.reg_write = 1'b1;
                end
                OP_LW: begin
                    id_ex_next.alu_src   = 1'b1;
                    id_ex_next.reg_write = 1'b1;
                    id_ex_next.mem_read  = 1'b1;
                end
                OP_SW: begin
                    id_ex_next.alu_src   = 1'b1;
                    id_ex_next.mem_write = 1'b1;
                end
                OP_BEQ:  id_ex_next.branch = 1'b1;
                default: id_ex_next.valid  = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
            halt_seen   <= 1'b0;
        end else if (!freeze) begin
            id_ex <= id_ex_next;
            if (id_ex_next.valid && id_ex_next.halt) begin
                halt_seen <= 1'b1;              // Stops fetch from here on.
            end
        end
    end

endmodule

// File: decode/register_file.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::reg_num_t rs_num,
    input  mips_pkg::reg_num_t rt_num,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    input  mips_pkg::mem_wb_t  mem_wb
);
    import mips_pkg::*;

    word_t regs [1:`MIPS_REG_COUNT-1];     // Register zero has no storage.
    logic  wr_en;

    assign wr_en = !rst && mem_wb.valid && mem_wb.reg_write && (mem_wb.dest != '0);

    // Write data bypasses to a read of the same register.
    function automatic word_t read_reg(input reg_num_t num);
        if (num == '0) begin
            return '0;
        end else if (wr_en && (num == mem_wb.dest)) begin
            return mem_wb.result;
        end
        return regs[num];
    endfunction

    always_comb begin
        rs_data = read_reg(rs_num);
        rt_data = read_reg(rt_num);
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[mem_wb.dest] <= mem_wb.result;
        end
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              freeze,
    input  mips_pkg::id_ex_t  id_ex,
    output logic              branch_taken,
    output mips_pkg::word_t   branch_target,
    output mips_pkg::ex_mem_t ex_mem
);
    import mips_pkg::*;

    word_t operand_b;
    word_t alu_result;

    assign operand_b = id_ex.alu_src ? id_ex.imm : id_ex.rt_data;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_result = id_ex.rs_data - operand_b;
            ALU_AND: alu_result = id_ex.rs_data & operand_b;
            ALU_OR:  alu_result = id_ex.rs_data | operand_b;
            ALU_SLT: alu_result = word_t'($signed(id_ex.rs_data) < $signed(operand_b));
            default: alu_result = id_ex.rs_data + operand_b;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Branch resolution
    assign branch_taken  = id_ex.valid && id_ex.branch && (id_ex.rs_data == id_ex.rt_data);
    assign branch_target = id_ex.pc_plus4 + (id_ex.imm << 2);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else if (!freeze) begin
            ex_mem.valid      <= id_ex.valid;   // The branch itself retires.
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex.rt_data;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.halt       <= id_ex.halt;
        end
    end

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              rst,
    input  mips_pkg::ex_mem_t ex_mem,
    output logic              freeze,
    output mips_pkg::word_t   mem_addr,
    output mips_pkg::word_t   mem_wdata,
    output logic              mem_write_en,
    output logic              mem_read_en,
    input  mips_pkg::word_t   mem_rdata,
    input  logic              mem_ready,
    output mips_pkg::mem_wb_t mem_wb
);
    import mips_pkg::*;

    mem_state_e state;
    mem_state_e state_next;
    logic       mem_access;
    logic       req_open;
    word_t      result;

    assign mem_access   = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
    assign req_open     = mem_access || (state == MEM_WAIT);
    assign freeze       = req_open && !mem_ready;

    // Request fields come straight from ex_mem, which freeze holds steady.
    assign mem_addr     = ex_mem.alu_result;
    assign mem_wdata    = ex_mem.store_data;
    assign mem_read_en  = mem_access && ex_mem.mem_read;
    assign mem_write_en = mem_access && ex_mem.mem_write;

    assign result = ex_mem.mem_read ? mem_rdata : ex_mem.alu_result;

    always_comb begin
        state_next = state;
        case (state)
            MEM_IDLE: if (mem_access && !mem_ready) state_next = MEM_WAIT;
            MEM_WAIT: if (mem_ready) state_next = MEM_IDLE;
            default:  state_next = MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= MEM_IDLE;
            mem_wb.valid <= 1'b0;
            mem_wb.halt  <= 1'b0;
        end else begin
            state            <= state_next;
            mem_wb.valid     <= ex_mem.valid && !freeze;    // Bubble while waiting.
            mem_wb.result    <= result;
            mem_wb.dest      <= ex_mem.dest;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.halt      <= mem_wb.halt || (ex_mem.valid && ex_mem.halt && !freeze);
        end
    end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ps

module mips_core (
    input  logic            clk,
    input  logic            rst,
    output mips_pkg::word_t inst_addr,
    input  mips_pkg::word_t inst,
    output mips_pkg::word_t mem_addr,
    output mips_pkg::word_t mem_wdata,
    output logic            mem_write_en,
    output logic            mem_read_en,
    input  mips_pkg::word_t mem_rdata,
    input  logic            mem_ready,
    output logic            halted
);
    import mips_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     freeze;           // Whole pipeline holds on a slow access.
    logic     branch_taken;
    word_t    branch_target;
    logic     halt_seen;
    reg_num_t rs_num;
    reg_num_t rt_num;
    word_t    rs_data;
    word_t    rt_data;

    assign halted = mem_wb.halt;

    fetch_stage i_fetch_stage (
        .clk(clk),
        .rst(rst),
        .freeze(freeze),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .halt_seen(halt_seen),
        .inst_addr(inst_addr),
        .inst(inst),
        .if_id(if_id)
    );

    decode_stage i_decode_stage (
        .clk(clk),
        .rst(rst),
        .freeze(freeze),
        .branch_taken(branch_taken),
        .if_id(if_id),
        .rs_num(rs_num),
        .rt_num(rt_num),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .halt_seen(halt_seen),
        .id_ex(id_ex)
    );

    register_file i_register_file (
        .clk(clk),
        .rst(rst),
        .rs_num(rs_num),
        .rt_num(rt_num),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .mem_wb(mem_wb)
    );

    execute_stage i_execute_stage (
        .clk(clk),
        .rst(rst),
        .freeze(freeze),
        .id_ex(id_ex),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .ex_mem(ex_mem)
    );

    memory_stage i_memory_stage (
        .clk(clk),
        .rst(rst),
        .ex_mem(ex_mem),
        .freeze(freeze),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_write_en(mem_write_en),
        .mem_read_en(mem_read_en),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .mem_wb(mem_wb)
    );

endmodule

// File: dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: dv/mips_core_props.sv
`timescale 1ns/1ps

module mips_core_props (
    input logic            clk,
    input logic            rst,
    input mips_pkg::word_t mem_addr,
    input mips_pkg::word_t mem_wdata,
    input logic            mem_write_en,
    input logic            mem_read_en,
    input logic            mem_ready,
    input logic            halted
);

    int fail_count = 0;                 // Read by the testbench.

    a_one_access: assert property (@(posedge clk) disable iff (rst)
        !(mem_read_en && mem_write_en))
    else begin
        $error("read and write enable are high together");
        fail_count++;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // A waiting request must not move.
    a_request_holds: assert property (@(posedge clk) disable iff (rst)
        (mem_read_en || mem_write_en) && !mem_ready |=>
            $stable(mem_addr) && $stable(mem_wdata) &&
            $stable(mem_read_en) && $stable(mem_write_en))
    else begin
        $error("request changed while waiting for mem_ready");
        fail_count++;
    end

    a_halt_sticky: assert property (@(posedge clk)
        halted && !rst |=> halted)
    else begin
        $error("halted fell without reset");
        fail_count++;
    end

endmodule

bind mips_core mips_core_props i_props (
    .clk(clk),
    .rst(rst),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_write_en(mem_write_en),
    .mem_read_en(mem_read_en),
    .mem_ready(mem_ready),
    .halted(halted)
);

// File: dv/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD_NS  = 100;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_ROWS       = 27;
    localparam int CYCLES_PER_ROW = 40;
    localparam int SETTLE_CYCLES  = 20;     // Quiet time after halt.
    localparam int MEM_WORDS      = 64;     // Word index is address bits 7:2.

    // ~~~~~~~~~~~~~~~~~~~~
    // MIPS encodings
    localparam logic [5:0] OPC_ADDI = 6'h08;
    localparam logic [5:0] OPC_LW   = 6'h23;
    localparam logic [5:0] OPC_SW   = 6'h2b;
    localparam logic [5:0] OPC_BEQ  = 6'h04;
    localparam logic [5:0] FUN_ADD  = 6'h20;
    localparam logic [5:0] FUN_SUB  = 6'h22;
    localparam logic [5:0] FUN_AND  = 6'h24;
    localparam logic [5:0] FUN_OR   = 6'h25;
    localparam logic [5:0] FUN_SLT  = 6'h2a;

    typedef struct packed {
        word_t inst;
        logic  store;                       // Row expects a store.
        word_t addr;
        word_t data;
    } row_t;

    logic  clk;
    logic  rst       = 1'b1;
    word_t inst      = '0;
    word_t mem_rdata = '0;
    logic  mem_ready = 1'b0;
    word_t inst_addr;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_write_en;
    logic  mem_read_en;
    logic  halted;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    row_t  rows [NUM_ROWS];
    int    row_count   = 0;
    int    num_stores  = 0;
    int    store_count = 0;
    int    row_ptr     = 0;             // Next expected store row.
    int    seed        = 32'h3efbea67;
    int    rnd         = 0;
    logic  halt_rose   = 1'b0;

    clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock_gen (.clk(clk));

    mips_core i_dut (
        .clk(clk),
        .rst(rst),
        .inst_addr(inst_addr),
        .inst(inst),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_write_en(mem_write_en),
        .mem_read_en(mem_read_en),
        .mem_rdata(mem_rdata),
        .mem_ready(mem_ready),
        .halted(halted)
    );

    function automatic word_t rtype_word(input logic [5:0] funct, input int rd, input int rs,
                                         input int rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input int rt, input int rs,
                                         input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'ha5c3_0f5a;
    endfunction

    task automatic end_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0d ns: %s", $time, what);
        end_with_failure();
    endtask

    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic add_row(input word_t inst_word, input logic store, input word_t addr,
                           input word_t data);
        rows[row_count] = {inst_word, store, addr, data};
        if (store) begin
            num_stores++;
        end
        row_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Program and expected stores
    task automatic build_table();
        add_row(itype_word(OPC_ADDI, 1, 0, 7), 1'b0, '0, '0);
        add_row(itype_word(OPC_ADDI, 2, 0, 5), 1'b0, '0, '0);
        add_row(itype_word(OPC_ADDI, 3, 0, -4), 1'b0, '0, '0);
        add_row(itype_word(OPC_ADDI, 4, 0, 'h40), 1'b0, '0, '0);
        add_row(rtype_word(FUN_ADD, 5, 1, 2), 1'b0, '0, '0);
        add_row(rtype_word(FUN_SUB, 6, 1, 2), 1'b0, '0, '0);
        add_row(rtype_word(FUN_AND, 7, 1, 2), 1'b0, '0, '0);
        add_row(rtype_word(FUN_OR, 8, 1, 2), 1'b0, '0, '0);
        add_row(rtype_word(FUN_SLT, 9, 3, 1), 1'b0, '0, '0);        // -4 < 7.
        add_row(rtype_word(FUN_SLT, 11, 1, 3), 1'b0, '0, '0);
        add_row(itype_word(OPC_LW, 10, 4, 0), 1'b0, '0, '0);
        add_row(itype_word(OPC_SW, 5, 0, 'h80), 1'b1, 32'h80, 32'd12);
        add_row(itype_word(OPC_SW, 6, 0, 'h84), 1'b1, 32'h84, 32'd2);
        add_row(itype_word(OPC_SW, 10, 0, 'ha0), 1'b1, 32'ha0, fill_word(32'h40));
        add_row(itype_word(OPC_SW, 7, 0, 'h88), 1'b1, 32'h88, 32'd5);
        add_row(itype_word(OPC_SW, 8, 0, 'h8c), 1'b1, 32'h8c, 32'd7);
        add_row(itype_word(OPC_SW, 9, 0, 'h90), 1'b1, 32'h90, 32'd1);
        add_row(itype_word(OPC_SW, 11, 0, 'h94), 1'b1, 32'h94, 32'd0);
        add_row(itype_word(OPC_SW, 3, 0, 'h98), 1'b1, 32'h98, 32'hffff_fffc);
        add_row(itype_word(OPC_BEQ, 2, 1, 2), 1'b0, '0, '0);        // Not taken.
        add_row(itype_word(OPC_SW, 1, 0, 'ha4), 1'b1, 32'ha4, 32'd7);
        add_row(itype_word(OPC_BEQ, 1, 1, 2), 1'b0, '0, '0);        // Taken, skips two.
        add_row(itype_word(OPC_SW, 2, 0, 'ha8), 1'b0, '0, '0);
        add_row(itype_word(OPC_SW, 2, 0, 'hac), 1'b0, '0, '0);
        add_row(itype_word(OPC_SW, 2, 0, 'hb0), 1'b1, 32'hb0, 32'd5);
        add_row(`MIPS_HALT_WORD, 1'b0, '0, '0);
        add_row(itype_word(OPC_SW, 1, 0, 'hb4), 1'b0, '0, '0);      // Must never run.
    endtask

    task automatic check_store();
        while (row_ptr < NUM_ROWS && !rows[row_ptr].store) begin
            row_ptr++;
        end
        if (row_ptr >= NUM_ROWS) begin
            report_problem("a store was made beyond the expected ones");
        end else begin
            compare_value("mem_addr", mem_addr, rows[row_ptr].addr);
            compare_value("mem_wdata", mem_wdata, rows[row_ptr].data);
            dmem[mem_addr[7:2]] = mem_wdata;
            row_ptr++;
            store_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Memory models and checks
    always @(negedge clk) begin
        if (inst_addr < word_t'(MEM_WORDS * 4)) begin
            inst = imem[inst_addr[7:2]];
        end else begin
            inst = '0;
        end
        rnd       = $random(seed);
        mem_ready = (rnd[1:0] != 2'b00);                // Ready about three cycles in four.
        mem_rdata = 32'h0bad_0bad;                      // Junk until the access completes.
        if (!rst && (mem_read_en || mem_write_en)) begin
            if (mem_addr >= word_t'(MEM_WORDS * 4)) begin
                report_problem("data access outside the memory model");
            end
            if (mem_ready && mem_read_en) begin
                mem_rdata = dmem[mem_addr[7:2]];
            end
            if (mem_ready && mem_write_en) begin
                check_store();
            end
        end
        if (halted === 1'b1 && !halt_rose) begin
            halt_rose = 1'b1;
            if (store_count != num_stores) begin
                report_problem("halted rose before all expected stores were seen");
            end
        end
        if (halt_rose) begin
            compare_value("halted", word_t'(halted), word_t'(1));
        end
        if (i_dut.i_props.fail_count != 0) begin
            report_problem("a bound assertion failed");
        end
    end

    initial begin
        repeat (RESET_CYCLES + SETTLE_CYCLES + CYCLES_PER_ROW * NUM_ROWS) @(posedge clk);
        report_problem("timeout, the core did not finish the program in time");
    end

    initial begin
        build_table();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(word_t'(i * 4));
        end
        for (int i = 0; i < row_count; i++) begin
            imem[i] = rows[i].inst;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (store_count == num_stores && halted === 1'b1) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_problem("the run ended without all expected stores");
        end
    end

endmodule

// File: sources.f
+incdir+common
common/mips_pkg.sv
logic/fetch_stage.sv
decode/decode_stage.sv
decode/register_file.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_core.sv
dv/clock_gen.sv
dv/mips_core_props.sv
dv/mips_core_tb.sv

// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= mips_core_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
